/* core_pkg.sv */
`default_nettype none

package core_pkg;

    // datapath and register file geometry.
    localparam int XLEN           = 32;  // width of every data word.
    localparam int ARCH_REG_COUNT = 32;  // registers visible to software.
    localparam int PHYS_REG_COUNT = 64;  // registers behind the rename map.

    // index widths.
    localparam int AREG_W = 5;  // indexes the architectural registers.
    localparam int PREG_W = 6;  // indexes the physical registers.
    localparam int TAG_W  = 6;  // wide enough for 64 outstanding instructions.

    // execution unit latencies.
    localparam int MUL_STAGES = 3;   // registered stages in the multiplier.
    localparam int DIV_CYCLES = 32;  // one quotient bit per iteration.

endpackage

`default_nettype wire

/* div_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic [core_pkg::XLEN-1:0]   a,
    input  logic [core_pkg::XLEN-1:0]   b,
    input  logic [core_pkg::PREG_W-1:0] preg,
    input  logic [core_pkg::TAG_W-1:0]  tag,
    output logic                        busy,
    output logic                        wb_valid,
    output logic [core_pkg::PREG_W-1:0] wb_preg,
    output logic [core_pkg::TAG_W-1:0]  wb_tag,
    output logic [core_pkg::XLEN-1:0]   wb_data
);
    import core_pkg::*;

    logic            run;
    logic [5:0]      iter_cnt;
    logic            last;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dsr_q;
    logic [XLEN-1:0] rem_shift;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] quo_next;

    // shift the next dividend bit into the remainder and try the subtraction.
    assign rem_shift = {rem_q[XLEN-2:0], quo_q[XLEN-1]};
    assign diff      = {1'b0, rem_shift} - {1'b0, dsr_q};
    // a zero divisor never borrows, giving all ones.
    assign quo_next  = {quo_q[XLEN-2:0], ~diff[XLEN]};
    assign last      = run && (iter_cnt == 6'(DIV_CYCLES - 1));
    assign busy      = run || wb_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            run      <= 1'b0;
            iter_cnt <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= last;
            if (start && !busy) begin
                run      <= 1'b1;
                iter_cnt <= '0;
            end else if (run) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (last) run <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            quo_q   <= a;
            rem_q   <= '0;
            dsr_q   <= b;
            wb_preg <= preg;
            wb_tag  <= tag;
        end else if (run) begin
            quo_q <= quo_next;
            rem_q <= diff[XLEN] ? rem_shift : diff[XLEN-1:0];  // restore on borrow.
        end
        if (last) wb_data <= quo_next;
    end

endmodule

`default_nettype wire

/* exec_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  isa_pkg::opcode_t            instr_op,
    input  logic [core_pkg::AREG_W-1:0] instr_rd,
    input  logic [core_pkg::AREG_W-1:0] instr_rs1,
    input  logic [core_pkg::AREG_W-1:0] instr_rs2,
    input  logic [core_pkg::XLEN-1:0]   instr_imm,
    input  logic [core_pkg::TAG_W-1:0]  instr_tag,
    output logic                        instr_ready,
    output logic                        busy,
    output logic                        alu_done_valid,
    output logic [core_pkg::TAG_W-1:0]  alu_done_tag,
    output logic [core_pkg::XLEN-1:0]   alu_done_data,
    output logic                        mul_done_valid,
    output logic [core_pkg::TAG_W-1:0]  mul_done_tag,
    output logic [core_pkg::XLEN-1:0]   mul_done_data,
    output logic                        div_done_valid,
    output logic [core_pkg::TAG_W-1:0]  div_done_tag,
    output logic [core_pkg::XLEN-1:0]   div_done_data
);
    import core_pkg::*;

    logic [AREG_W-1:0] held_rd, held_rs1, held_rs2;
    logic [PREG_W-1:0] src1_preg, src2_preg, old_preg, new_preg;
    logic [PREG_W-1:0] issue_preg, alu_wb_preg, mul_wb_preg, div_wb_preg;
    logic [XLEN-1:0]   src1_data, src2_data, issue_a, issue_b;
    logic [TAG_W-1:0]  issue_tag;
    logic              src1_valid, src2_valid, old_valid, free_empty;
    logic              alloc, issue_mul, issue_div, div_busy;

    issue_control issue_i (
        .clk, .reset, .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2,
        .instr_imm, .instr_tag, .src1_valid, .src2_valid, .old_valid, .free_empty,
        .new_preg, .src1_data, .src2_data, .div_busy, .instr_ready, .alloc,
        .held_rd, .held_rs1, .held_rs2, .issue_alu(), .issue_mul, .issue_div,
        .issue_op(), .issue_a, .issue_b, .issue_preg, .issue_tag,
        .alu_wb_valid(alu_done_valid), .alu_wb_preg, .alu_wb_tag(alu_done_tag),
        .alu_wb_data(alu_done_data), .busy
    );

    rename_table rename_i (
        .clk, .reset, .rs1(held_rs1), .rs2(held_rs2), .rd(held_rd), .alloc,
        .src1_preg, .src2_preg, .old_preg, .new_preg, .free_empty
    );

    physical_register_file prf_i (
        .clk, .reset, .rd1_preg(src1_preg), .rd2_preg(src2_preg), .probe_preg(old_preg),
        .alloc, .alloc_preg(issue_preg),
        .alu_wb_valid(alu_done_valid), .alu_wb_preg, .alu_wb_data(alu_done_data),
        .mul_wb_valid(mul_done_valid), .mul_wb_preg, .mul_wb_data(mul_done_data),
        .div_wb_valid(div_done_valid), .div_wb_preg, .div_wb_data(div_done_data),
        .rd1_data(src1_data), .rd2_data(src2_data), .rd1_valid(src1_valid),
        .rd2_valid(src2_valid), .probe_valid(old_valid)
    );

    mul_pipe mul_i (
        .clk, .reset, .start(issue_mul), .a(issue_a), .b(issue_b), .preg(issue_preg),
        .tag(issue_tag), .wb_valid(mul_done_valid), .wb_preg(mul_wb_preg),
        .wb_tag(mul_done_tag), .wb_data(mul_done_data)
    );

    div_unit div_i (
        .clk, .reset, .start(issue_div), .a(issue_a), .b(issue_b), .preg(issue_preg),
        .tag(issue_tag), .busy(div_busy), .wb_valid(div_done_valid),
        .wb_preg(div_wb_preg), .wb_tag(div_done_tag), .wb_data(div_done_data)
    );

endmodule

`default_nettype wire

/* files.f */
core_pkg.sv
isa_pkg.sv
physical_register_file.sv
rename_table.sv
issue_control.sv
mul_pipe.sv
div_unit.sv
exec_core_top.sv
tb_exec_core.sv

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef enum logic [2:0] {
        OP_ADD,  // rd = rs1 + rs2.
        OP_SUB,  // rd = rs1 - rs2.
        OP_LI,   // rd = imm.
        OP_MUL,  // rd = low half of rs1 * rs2.
        OP_DIV   // rd = rs1 / rs2, unsigned.
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_t;

    // Load-immediate shares the ALU since it needs no memory port.
    function automatic unit_t unit_of(input opcode_t op);
        case (op)
            OP_MUL:  return UNIT_MUL;
            OP_DIV:  return UNIT_DIV;
            default: return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

/* issue_control.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_control (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  isa_pkg::opcode_t            instr_op,
    input  logic [core_pkg::AREG_W-1:0] instr_rd,
    input  logic [core_pkg::AREG_W-1:0] instr_rs1,
    input  logic [core_pkg::AREG_W-1:0] instr_rs2,
    input  logic [core_pkg::XLEN-1:0]   instr_imm,
    input  logic [core_pkg::TAG_W-1:0]  instr_tag,
    input  logic                        src1_valid,
    input  logic                        src2_valid,
    input  logic                        old_valid,
    input  logic                        free_empty,
    input  logic [core_pkg::PREG_W-1:0] new_preg,
    input  logic [core_pkg::XLEN-1:0]   src1_data,
    input  logic [core_pkg::XLEN-1:0]   src2_data,
    input  logic                        div_busy,
    output logic                        instr_ready,
    output logic                        alloc,
    output logic [core_pkg::AREG_W-1:0] held_rd,
    output logic [core_pkg::AREG_W-1:0] held_rs1,
    output logic [core_pkg::AREG_W-1:0] held_rs2,
    output logic                        issue_alu,
    output logic                        issue_mul,
    output logic                        issue_div,
    output isa_pkg::opcode_t            issue_op,
    output logic [core_pkg::XLEN-1:0]   issue_a,
    output logic [core_pkg::XLEN-1:0]   issue_b,
    output logic [core_pkg::PREG_W-1:0] issue_preg,
    output logic [core_pkg::TAG_W-1:0]  issue_tag,
    output logic                        alu_wb_valid,
    output logic [core_pkg::PREG_W-1:0] alu_wb_preg,
    output logic [core_pkg::TAG_W-1:0]  alu_wb_tag,
    output logic [core_pkg::XLEN-1:0]   alu_wb_data,
    output logic                        busy
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef enum logic {ST_IDLE, ST_WAIT} state_t;

    state_t                state;
    opcode_t               held_op;
    logic [XLEN-1:0]       held_imm;
    logic [TAG_W-1:0]      held_tag;
    unit_t                 held_unit;
    logic                  unit_ok;
    logic                  go;
    logic [MUL_STAGES-1:0] mul_track;  // mirrors the multiplier's stage valids.

    assign held_unit = unit_of(held_op);
    assign unit_ok   = (held_unit != UNIT_DIV) || !div_busy;
    assign go        = (state == ST_WAIT) && src1_valid && src2_valid && old_valid
                       && !free_empty && unit_ok;

    assign instr_ready = (state == ST_IDLE);
    assign alloc       = go;
    assign issue_alu   = go && (held_unit == UNIT_ALU);
    assign issue_mul   = go && (held_unit == UNIT_MUL);
    assign issue_div   = go && (held_unit == UNIT_DIV);
    assign issue_op    = held_op;
    assign issue_a     = src1_data;
    assign issue_b     = (held_op == OP_LI) ? held_imm : src2_data;
    assign issue_preg  = (held_rd == '0) ? '0 : new_preg;  // x0 results are dropped.
    assign issue_tag   = held_tag;
    assign busy        = (state == ST_WAIT) || alu_wb_valid || (|mul_track) || div_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            mul_track    <= '0;
            alu_wb_valid <= 1'b0;
        end else begin
            mul_track    <= {mul_track[MUL_STAGES-2:0], issue_mul};
            alu_wb_valid <= issue_alu;
            case (state)
                ST_IDLE: if (instr_valid) state <= ST_WAIT;
                ST_WAIT: if (go) state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            held_op  <= instr_op;
            held_rd  <= instr_rd;
            held_rs1 <= instr_rs1;
            held_rs2 <= instr_rs2;
            held_imm <= instr_imm;
            held_tag <= instr_tag;
        end
        // single-cycle ALU writing back on the cycle after issue.
        if (issue_alu) begin
            alu_wb_preg <= issue_preg;
            alu_wb_tag  <= issue_tag;
            case (issue_op)
                OP_ADD:  alu_wb_data <= issue_a + issue_b;
                OP_SUB:  alu_wb_data <= issue_a - issue_b;
                default: alu_wb_data <= issue_b;  // load-immediate passes the immediate.
            endcase
        end
    end

endmodule

`default_nettype wire

/* mul_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_pipe (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic [core_pkg::XLEN-1:0]   a,
    input  logic [core_pkg::XLEN-1:0]   b,
    input  logic [core_pkg::PREG_W-1:0] preg,
    input  logic [core_pkg::TAG_W-1:0]  tag,
    output logic                        wb_valid,
    output logic [core_pkg::PREG_W-1:0] wb_preg,
    output logic [core_pkg::TAG_W-1:0]  wb_tag,
    output logic [core_pkg::XLEN-1:0]   wb_data
);
    import core_pkg::*;

    logic [MUL_STAGES-1:0] vld_q;
    logic [PREG_W-1:0]     preg_q [MUL_STAGES];
    logic [TAG_W-1:0]      tag_q  [MUL_STAGES];
    logic [XLEN-1:0]       a_q;
    logic [XLEN-1:0]       b_q;
    logic [XLEN-1:0]       prod_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], start};  // a new item may enter every cycle.
        end
    end

    always_ff @(posedge clk) begin
        a_q     <= a;           // stage one captures the operands.
        b_q     <= b;
        prod_q  <= a_q * b_q;   // stage two keeps the low half of the product.
        wb_data <= prod_q;      // stage three drives the write port.
        preg_q[0] <= preg;
        tag_q[0]  <= tag;
        for (int i = 1; i < MUL_STAGES; i++) begin
            preg_q[i] <= preg_q[i-1];
            tag_q[i]  <= tag_q[i-1];
        end
    end

    assign wb_valid = vld_q[MUL_STAGES-1];
    assign wb_preg  = preg_q[MUL_STAGES-1];
    assign wb_tag   = tag_q[MUL_STAGES-1];

endmodule

`default_nettype wire

/* physical_register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module physical_register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [core_pkg::PREG_W-1:0] rd1_preg,
    input  logic [core_pkg::PREG_W-1:0] rd2_preg,
    input  logic [core_pkg::PREG_W-1:0] probe_preg,
    input  logic                        alloc,
    input  logic [core_pkg::PREG_W-1:0] alloc_preg,
    input  logic                        alu_wb_valid,
    input  logic [core_pkg::PREG_W-1:0] alu_wb_preg,
    input  logic [core_pkg::XLEN-1:0]   alu_wb_data,
    input  logic                        mul_wb_valid,
    input  logic [core_pkg::PREG_W-1:0] mul_wb_preg,
    input  logic [core_pkg::XLEN-1:0]   mul_wb_data,
    input  logic                        div_wb_valid,
    input  logic [core_pkg::PREG_W-1:0] div_wb_preg,
    input  logic [core_pkg::XLEN-1:0]   div_wb_data,
    output logic [core_pkg::XLEN-1:0]   rd1_data,
    output logic [core_pkg::XLEN-1:0]   rd2_data,
    output logic                        rd1_valid,
    output logic                        rd2_valid,
    output logic                        probe_valid
);
    import core_pkg::*;

    logic [XLEN-1:0]           rf_data [PHYS_REG_COUNT];
    logic [PHYS_REG_COUNT-1:0] rf_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REG_COUNT; i++) begin
                // the first bank starts out holding its own index.
                rf_data[i] <= (i < ARCH_REG_COUNT) ? XLEN'(i) : '0;
            end
            rf_valid <= '1;
        end else begin
            if (alu_wb_valid && alu_wb_preg != '0) begin
                rf_data[alu_wb_preg]  <= alu_wb_data;
                rf_valid[alu_wb_preg] <= 1'b1;
            end
            if (mul_wb_valid && mul_wb_preg != '0) begin
                rf_data[mul_wb_preg]  <= mul_wb_data;
                rf_valid[mul_wb_preg] <= 1'b1;
            end
            if (div_wb_valid && div_wb_preg != '0) begin
                rf_data[div_wb_preg]  <= div_wb_data;
                rf_valid[div_wb_preg] <= 1'b1;
            end
            // a fresh destination stays pending until its unit writes back.
            if (alloc && alloc_preg != '0) begin
                rf_valid[alloc_preg] <= 1'b0;
            end
        end
    end

    assign rd1_data    = rf_data[rd1_preg];
    assign rd2_data    = rf_data[rd2_preg];
    assign rd1_valid   = rf_valid[rd1_preg];
    assign rd2_valid   = rf_valid[rd2_preg];
    assign probe_valid = rf_valid[probe_preg];  // tells whether the old writer is done.

endmodule

`default_nettype wire

/* rename_table.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_table (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [core_pkg::AREG_W-1:0] rs1,
    input  logic [core_pkg::AREG_W-1:0] rs2,
    input  logic [core_pkg::AREG_W-1:0] rd,
    input  logic                        alloc,
    output logic [core_pkg::PREG_W-1:0] src1_preg,
    output logic [core_pkg::PREG_W-1:0] src2_preg,
    output logic [core_pkg::PREG_W-1:0] old_preg,
    output logic [core_pkg::PREG_W-1:0] new_preg,
    output logic                        free_empty
);
    import core_pkg::*;

    logic [PREG_W-1:0] map_q  [ARCH_REG_COUNT];
    logic [PREG_W-1:0] free_q [PHYS_REG_COUNT-ARCH_REG_COUNT];
    logic [AREG_W-1:0] head_q;
    logic [AREG_W-1:0] tail_q;
    logic [PREG_W-1:0] free_count;
    logic              pop;
    logic              push;

    assign pop  = alloc && (rd != '0);      // x0 never gets a new mapping.
    assign push = pop && (old_preg != '0);  // the zero register is never freed.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REG_COUNT; i++) begin
                map_q[i] <= PREG_W'(i);
            end
            // the upper bank starts out free.
            for (int i = 0; i < PHYS_REG_COUNT - ARCH_REG_COUNT; i++) begin
                free_q[i] <= PREG_W'(ARCH_REG_COUNT + i);
            end
            head_q     <= '0;
            tail_q     <= '0;
            free_count <= PREG_W'(PHYS_REG_COUNT - ARCH_REG_COUNT);
        end else begin
            if (pop) begin
                map_q[rd] <= free_q[head_q];
                head_q    <= head_q + 1'b1;  // the pointer wraps with the queue depth.
            end
            if (push) begin
                free_q[tail_q] <= old_preg;
                tail_q         <= tail_q + 1'b1;
            end
            free_count <= free_count + PREG_W'(push) - PREG_W'(pop);
        end
    end

    assign src1_preg  = map_q[rs1];
    assign src2_preg  = map_q[rs2];
    assign old_preg   = map_q[rd];
    assign new_preg   = free_q[head_q];
    assign free_empty = (free_count == '0);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_exec_core \
    --Mdir obj_dir -o sim_exec_core
./obj_dir/sim_exec_core | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* tb_exec_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_core;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int NUM_INSTR     = 400;
    localparam int MAX_IN_FLIGHT = 60;  // keeps tags unique while modulo 64.

    logic              clk;
    logic              reset;
    logic              instr_valid;
    opcode_t           instr_op;
    logic [AREG_W-1:0] instr_rd;
    logic [AREG_W-1:0] instr_rs1;
    logic [AREG_W-1:0] instr_rs2;
    logic [XLEN-1:0]   instr_imm;
    logic [TAG_W-1:0]  instr_tag;
    logic              instr_ready;
    logic              busy;
    logic              alu_done_valid;
    logic [TAG_W-1:0]  alu_done_tag;
    logic [XLEN-1:0]   alu_done_data;
    logic              mul_done_valid;
    logic [TAG_W-1:0]  mul_done_tag;
    logic [XLEN-1:0]   mul_done_data;
    logic              div_done_valid;
    logic [TAG_W-1:0]  div_done_tag;
    logic [XLEN-1:0]   div_done_data;

    logic [XLEN-1:0]   arch_x   [ARCH_REG_COUNT];  // architectural state in program order.
    logic [XLEN-1:0]   exp_data [64];
    unit_t             exp_unit [64];
    logic [63:0]       pending;
    logic [31:0]       rng;
    logic [TAG_W-1:0]  next_tag;
    opcode_t           op;
    logic [AREG_W-1:0] rd;
    logic [AREG_W-1:0] rs1;
    logic [AREG_W-1:0] rs2;
    logic [XLEN-1:0]   imm;
    int                gap;
    int                err_count;
    int                accept_count;
    int                done_count;

    exec_core_top dut_i (
        .clk, .reset, .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2,
        .instr_imm, .instr_tag, .instr_ready, .busy,
        .alu_done_valid, .alu_done_tag, .alu_done_data,
        .mul_done_valid, .mul_done_tag, .mul_done_data,
        .div_done_valid, .div_done_tag, .div_done_data
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // most picks land on x0..x3 so that instructions depend on each other.
    function automatic logic [AREG_W-1:0] pick_reg(input logic [31:0] r);
        if (r[2:0] < 3'd5) return {3'b000, r[4:3]};
        return r[9:5];
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // executes one instruction on the architectural model at its acceptance.
    task automatic record_model(input opcode_t o, input logic [AREG_W-1:0] d,
                                input logic [AREG_W-1:0] s1, input logic [AREG_W-1:0] s2,
                                input logic [XLEN-1:0] im, input logic [TAG_W-1:0] t);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        unit_t           u;
        a = arch_x[s1];
        b = arch_x[s2];
        case (o)
            OP_ADD: begin
                res = a + b;
                u   = UNIT_ALU;
            end
            OP_SUB: begin
                res = a - b;
                u   = UNIT_ALU;
            end
            OP_MUL: begin
                res = a * b;
                u   = UNIT_MUL;
            end
            OP_DIV: begin
                res = (b == '0) ? '1 : a / b;
                u   = UNIT_DIV;
            end
            default: begin
                res = im;
                u   = UNIT_ALU;
            end
        endcase
        exp_data[t] = res;
        exp_unit[t] = u;
        pending[t]  = 1'b1;
        if (d != '0) arch_x[d] = res;  // x0 keeps its zero.
        accept_count++;
    endtask

    task automatic send_instr(input opcode_t o, input logic [AREG_W-1:0] d,
                              input logic [AREG_W-1:0] s1, input logic [AREG_W-1:0] s2,
                              input logic [XLEN-1:0] im);
        instr_valid = 1'b1;
        instr_op    = o;
        instr_rd    = d;
        instr_rs1   = s1;
        instr_rs2   = s2;
        instr_imm   = im;
        instr_tag   = next_tag;
        @(negedge clk);
        while (instr_ready !== 1'b1) @(negedge clk);
        record_model(o, d, s1, s2, im, next_tag);  // the transfer lands on the next edge.
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        next_tag    = next_tag + 6'd1;
    endtask

    task automatic check_done(input unit_t u, input logic [TAG_W-1:0] t,
                              input logic [XLEN-1:0] data, input string name);
        if (!pending[t]) begin
            err_count++;
            $display("tag %0d completed on %s but was not outstanding at %0t", t, name, $time);
        end else begin
            if (exp_unit[t] != u) begin
                err_count++;
                $display("tag %0d completed on %s, which is the wrong unit", t, name);
            end
            if (data !== exp_data[t]) begin
                err_count++;
                $display("FAILED at %0t: %s_data for tag %0d expected %h got %h",
                         $time, name, t, exp_data[t], data);
            end
            pending[t] = 1'b0;
            done_count++;
        end
    endtask

    // completions may arrive in any order and are matched by tag.
    always @(negedge clk) begin
        if (!reset) begin
            if (alu_done_valid === 1'b1) begin
                check_done(UNIT_ALU, alu_done_tag, alu_done_data, "alu_done");
            end
            if (mul_done_valid === 1'b1) begin
                check_done(UNIT_MUL, mul_done_tag, mul_done_data, "mul_done");
            end
            if (div_done_valid === 1'b1) begin
                check_done(UNIT_DIV, div_done_tag, div_done_data, "div_done");
            end
        end
    end

    initial begin
        repeat (NUM_INSTR * 40 + 200) @(posedge clk);
        $display("timeout after %0d cycles, errors %0d, accepted %0d, completed %0d",
                 NUM_INSTR * 40 + 200, err_count, accept_count, done_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr_op     = OP_ADD;
        instr_rd     = '0;
        instr_rs1    = '0;
        instr_rs2    = '0;
        instr_imm    = '0;
        instr_tag    = '0;
        rng          = 32'hd28f;
        next_tag     = '0;
        pending      = '0;
        err_count    = 0;
        accept_count = 0;
        done_count   = 0;
        for (int i = 0; i < ARCH_REG_COUNT; i++) arch_x[i] = XLEN'(i);
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_bit("alu_done_valid", alu_done_valid, 1'b0);
        check_bit("mul_done_valid", mul_done_valid, 1'b0);
        check_bit("div_done_valid", div_done_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("instr_ready", instr_ready, 1'b1);
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            rng = xorshift32(rng);
            op  = opcode_t'(3'(rng % 32'd5));
            rng = xorshift32(rng);
            rd  = pick_reg(rng);
            rng = xorshift32(rng);
            rs1 = pick_reg(rng);
            rng = xorshift32(rng);
            rs2 = pick_reg(rng);
            if (op == OP_DIV && rng[31:29] == 3'd0) rs2 = '0;  // divide by zero.
            rng = xorshift32(rng);
            imm = rng[0] ? {20'd0, rng[12:1]} : rng;
            rng = xorshift32(rng);
            gap = (rng[2:0] < 3'd5) ? 0 : int'(rng[4:3]);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            while (accept_count - done_count >= MAX_IN_FLIGHT) begin
                @(posedge clk);
                #1;
            end
            send_instr(op, rd, rs1, rs2, imm);
        end
        @(negedge clk);
        while (busy !== 1'b0) @(negedge clk);
        @(negedge clk);
        if (done_count != accept_count) begin
            err_count++;
            $display("completed %0d instructions but accepted %0d", done_count, accept_count);
        end
        if (pending != '0) begin
            err_count++;
            $display("some tags never completed, outstanding mask %h", pending);
        end
        $display("errors %0d, accepted %0d, completed %0d", err_count, accept_count, done_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
